/* common/state_pkg.sv */
package state_pkg;

    // ----------------------------
    // Flow state
    // ----------------------------
    // 256 flows, one table entry each
    typedef logic [7:0] flow_id_t;

    typedef struct packed {
        logic [15:0] pkt_cnt;
        logic [23:0] byte_cnt;
    } flow_state_t;

    // ----------------------------
    // Update requests
    // ----------------------------
    typedef enum logic [1:0] {
        OP_INCR = 2'd0,
        OP_SET  = 2'd1,
        OP_READ = 2'd2
    } update_op_t;

    // Increment view, packet length in the low bits
    typedef struct packed {
        logic [23:0] pad;
        logic [15:0] len;
    } incr_arg_t;

    // Argument word, view picked by op
    typedef union packed {
        incr_arg_t   incr;
        flow_state_t set;
    } update_arg_u;

    typedef struct packed {
        flow_id_t    id;
        update_op_t  op;
        update_arg_u arg;
    } update_req_t;

    // Source tag for response steering
    typedef enum logic {
        SRC_DP   = 1'b0,
        SRC_CTRL = 1'b1
    } update_src_t;

    typedef struct packed {
        update_src_t src;
        flow_state_t state;
    } update_resp_t;

    // ----------------------------
    // Configuration
    // ----------------------------
    typedef enum logic [1:0] {
        CFG_CTRL   = 2'd0,
        CFG_STATUS = 2'd1
    } cfg_addr_t;

    typedef struct packed {
        cfg_addr_t  addr;
        logic       wr;
        logic [7:0] wdata;
    } cfg_req_t;

    // CFG_CTRL bit positions
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_SAT_BIT = 1;
    localparam int CTRL_INIT_BIT = 2;
    // CFG_STATUS bit positions
    localparam int STATUS_INIT_DONE_BIT = 0;

endpackage

/* hw/state_table.sv */
`timescale 1ns/1ns

module state_table #(
    parameter int TABLE_DEPTH = 256
)(
    input  logic                   clk,
    input  logic                   srst,
    // Init sweep
    input  logic                   init_start,
    output logic                   init_done,
    // Read port, data one cycle after rd_id
    input  state_pkg::flow_id_t    rd_id,
    output state_pkg::flow_state_t rd_state,
    // Write port
    input  logic                   wr_en,
    input  state_pkg::flow_id_t    wr_id,
    input  state_pkg::flow_state_t wr_state
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    state_pkg::flow_state_t mem [TABLE_DEPTH];

    logic             sweep_active;
    logic [IDX_W-1:0] sweep_idx;

    // ----------------------------
    // Clearing sweep
    // ----------------------------
    // One entry per cycle, restarted by reset or init_start
    always_ff @(posedge clk) begin
        if (srst || init_start) begin
            sweep_active <= 1'b1;
            sweep_idx    <= '0;
        end else if (sweep_active) begin
            sweep_idx <= sweep_idx + IDX_W'(1);
            // Last entry cleared this cycle
            if (sweep_idx == IDX_W'(TABLE_DEPTH - 1)) begin
                sweep_active <= 1'b0;
            end
        end
    end

    assign init_done = !sweep_active;

    // ----------------------------
    // Storage
    // ----------------------------
    // Sweep takes the write port while active
    always_ff @(posedge clk) begin
        if (sweep_active) begin
            mem[sweep_idx] <= '0;
        end else if (wr_en) begin
            mem[wr_id] <= wr_state;
        end
    end

    // Registered read, write-first on same-ID collision
    always_ff @(posedge clk) begin
        rd_state <= (wr_en && (wr_id == rd_id)) ? wr_state : mem[rd_id];
    end

endmodule

/* hw/update_arbiter.sv */
`timescale 1ns/1ns

module update_arbiter #(
    parameter int STARVE_LIMIT = 4
)(
    input  logic                    clk,
    input  logic                    srst,
    // Datapath source
    input  logic                    dp_req,
    input  state_pkg::update_req_t  dp_req_data,
    output logic                    dp_rdy,
    output logic                    dp_ack,
    output state_pkg::flow_state_t  dp_state,
    // Control plane source
    input  logic                    ctrl_req,
    input  state_pkg::update_req_t  ctrl_req_data,
    output logic                    ctrl_rdy,
    output logic                    ctrl_ack,
    output state_pkg::flow_state_t  ctrl_state,
    // Merged request to core
    output logic                    arb_req,
    output state_pkg::update_req_t  arb_data,
    output state_pkg::update_src_t  arb_src,
    input  logic                    core_rdy,
    // Response from core
    input  logic                    resp_valid,
    input  state_pkg::update_resp_t resp
);

    localparam int CNT_W = $clog2(STARVE_LIMIT + 1);

    logic [CNT_W-1:0] starve_cnt;
    logic             ctrl_turn;

    // ----------------------------
    // Grant
    // ----------------------------
    // Datapath first, control once the guard trips
    assign ctrl_turn = ctrl_req && (!dp_req || (starve_cnt == CNT_W'(STARVE_LIMIT)));

    assign arb_req  = dp_req || ctrl_req;
    assign arb_data = ctrl_turn ? ctrl_req_data : dp_req_data;
    assign arb_src  = ctrl_turn ? state_pkg::SRC_CTRL : state_pkg::SRC_DP;

    assign dp_rdy   = core_rdy && !ctrl_turn;
    assign ctrl_rdy = core_rdy && ctrl_turn;

    // Datapath grants taken while control was waiting
    always_ff @(posedge clk) begin
        if (srst) begin
            starve_cnt <= '0;
        end else if (core_rdy && ctrl_turn) begin
            starve_cnt <= '0;
        end else if (core_rdy && dp_req && ctrl_req) begin
            // Stays below the limit, control wins at the limit
            starve_cnt <= starve_cnt + CNT_W'(1);
        end else if (!ctrl_req) begin
            starve_cnt <= '0;
        end
    end

    // ----------------------------
    // Response steering
    // ----------------------------
    assign dp_ack     = resp_valid && (resp.src == state_pkg::SRC_DP);
    assign ctrl_ack   = resp_valid && (resp.src == state_pkg::SRC_CTRL);
    // State shared, only the ack tells the owner
    assign dp_state   = resp.state;
    assign ctrl_state = resp.state;

endmodule

/* hw/state_cfg_regs.sv */
`timescale 1ns/1ns

module state_cfg_regs (
    input  logic                clk,
    input  logic                srst,
    // Four-phase config port
    input  logic                cfg_req,
    input  state_pkg::cfg_req_t cfg_data,
    output logic                cfg_ack,
    output logic [7:0]          cfg_rdata,
    // Core steering
    input  logic                init_done,
    output logic                en,
    output logic                sat_en,
    output logic                init_start
);

    logic       access;
    logic       ctrl_wr;
    logic [7:0] rd_word;

    // First cycle of a request, ack not yet raised
    assign access  = cfg_req && !cfg_ack;
    assign ctrl_wr = access && cfg_data.wr && (cfg_data.addr == state_pkg::CFG_CTRL);

    // ----------------------------
    // Handshake and registers
    // ----------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            cfg_ack    <= 1'b0;
            en         <= 1'b0;
            sat_en     <= 1'b0;
            init_start <= 1'b0;
        end else begin
            // Ack follows req by one cycle, both edges
            cfg_ack    <= cfg_req;
            // Init bit is write-one, one-cycle pulse
            init_start <= ctrl_wr && cfg_data.wdata[state_pkg::CTRL_INIT_BIT];
            if (ctrl_wr) begin
                en     <= cfg_data.wdata[state_pkg::CTRL_EN_BIT];
                sat_en <= cfg_data.wdata[state_pkg::CTRL_SAT_BIT];
            end
        end
    end

    // Readback mux, init bit always reads 0
    always_comb begin
        rd_word = '0;
        case (cfg_data.addr)
            state_pkg::CFG_CTRL: begin
                rd_word[state_pkg::CTRL_EN_BIT]  = en;
                rd_word[state_pkg::CTRL_SAT_BIT] = sat_en;
            end
            state_pkg::CFG_STATUS: rd_word[state_pkg::STATUS_INIT_DONE_BIT] = init_done;
            default: rd_word = '0;
        endcase
    end

    // Captured with the access, valid while ack is high
    always_ff @(posedge clk) begin
        if (access) cfg_rdata <= rd_word;
    end

endmodule

/* state_vector_core/state_vector_core.sv */
`timescale 1ns/1ns

module state_vector_core (
    input  logic                    clk,
    input  logic                    srst,
    // Steering from config block and table
    input  logic                    en,
    input  logic                    sat_en,
    input  logic                    init_done,
    // Merged request from arbiter
    input  logic                    arb_req,
    input  state_pkg::update_req_t  arb_data,
    input  state_pkg::update_src_t  arb_src,
    output logic                    core_rdy,
    // Response, two cycles after acceptance
    output logic                    resp_valid,
    output state_pkg::update_resp_t resp,
    // Table read
    output state_pkg::flow_id_t     rd_id,
    input  state_pkg::flow_state_t  rd_state,
    // Table write
    output logic                    wr_en,
    output state_pkg::flow_id_t     wr_id,
    output state_pkg::flow_state_t  wr_state
);

    // Context carried from acceptance to the update stage
    typedef struct packed {
        state_pkg::flow_id_t    id;
        state_pkg::update_op_t  op;
        state_pkg::update_arg_u arg;
        state_pkg::update_src_t src;
        logic                   back_to_back;
    } rmw_ctxt_t;

    logic      accept;
    rmw_ctxt_t ctxt_in;
    rmw_ctxt_t ctxt_q;
    logic      s1_valid;

    state_pkg::flow_state_t prev_state;
    state_pkg::flow_state_t next_state;
    state_pkg::flow_state_t fwd_state;

    logic [16:0] pkt_sum;
    logic [24:0] byte_sum;

    // ----------------------------
    // Acceptance
    // ----------------------------
    // No back-pressure stage, only enable and init gate
    assign core_rdy = en && init_done;
    assign accept   = arb_req && core_rdy;

    // Table read goes out in the acceptance cycle
    assign rd_id = arb_data.id;

    assign ctxt_in.id  = arb_data.id;
    assign ctxt_in.op  = arb_data.op;
    assign ctxt_in.arg = arb_data.arg;
    assign ctxt_in.src = arb_src;
    // Same ID as the one in the update stage right now
    assign ctxt_in.back_to_back = s1_valid && (arb_data.id == ctxt_q.id);

    always_ff @(posedge clk) begin
        if (srst) s1_valid <= 1'b0;
        else      s1_valid <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept) ctxt_q <= ctxt_in;
    end

    // ----------------------------
    // Update stage
    // ----------------------------
    // Table missed the pending write, take the forwarded state
    assign prev_state = ctxt_q.back_to_back ? fwd_state : rd_state;

    always_comb begin
        pkt_sum    = {1'b0, prev_state.pkt_cnt} + 17'd1;
        byte_sum   = {1'b0, prev_state.byte_cnt} + {9'd0, ctxt_q.arg.incr.len};
        next_state = prev_state;
        case (ctxt_q.op)
            state_pkg::OP_INCR: begin
                // Clamp on carry out when saturating, else wrap
                next_state.pkt_cnt  = (sat_en && pkt_sum[16]) ? '1 : pkt_sum[15:0];
                next_state.byte_cnt = (sat_en && byte_sum[24]) ? '1 : byte_sum[23:0];
            end
            state_pkg::OP_SET: next_state = ctxt_q.arg.set;
            // Read leaves the entry alone
            default: next_state = prev_state;
        endcase
    end

    // Forward for a same-ID request accepted this cycle
    always_ff @(posedge clk) begin
        if (s1_valid) fwd_state <= next_state;
    end

    // ----------------------------
    // Write back and response
    // ----------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_en      <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            wr_en      <= s1_valid;
            resp_valid <= s1_valid;
        end
    end

    // Response carries the state before the update
    always_ff @(posedge clk) begin
        wr_id      <= ctxt_q.id;
        wr_state   <= next_state;
        resp.src   <= ctxt_q.src;
        resp.state <= prev_state;
    end

endmodule

/* hw/state_subsys_top.sv */
`timescale 1ns/1ns

module state_subsys_top #(
    parameter int STARVE_LIMIT = 4,
    parameter int TABLE_DEPTH  = 256
)(
    input  logic                   clk,
    input  logic                   srst,
    // Datapath updates
    input  logic                   dp_req,
    input  state_pkg::update_req_t dp_req_data,
    output logic                   dp_rdy,
    output logic                   dp_ack,
    output state_pkg::flow_state_t dp_state,
    // Control plane updates
    input  logic                   ctrl_req,
    input  state_pkg::update_req_t ctrl_req_data,
    output logic                   ctrl_rdy,
    output logic                   ctrl_ack,
    output state_pkg::flow_state_t ctrl_state,
    // Configuration
    input  logic                   cfg_req,
    input  state_pkg::cfg_req_t    cfg_data,
    output logic                   cfg_ack,
    output logic [7:0]             cfg_rdata
);

    // ----------------------------
    // Internal wiring
    // ----------------------------
    logic                    en;
    logic                    sat_en;
    logic                    init_start;
    logic                    init_done;
    logic                    arb_req;
    state_pkg::update_req_t  arb_data;
    state_pkg::update_src_t  arb_src;
    logic                    core_rdy;
    logic                    resp_valid;
    state_pkg::update_resp_t resp;
    state_pkg::flow_id_t     rd_id;
    state_pkg::flow_state_t  rd_state;
    logic                    wr_en;
    state_pkg::flow_id_t     wr_id;
    state_pkg::flow_state_t  wr_state;

    state_cfg_regs u_cfg (
        .clk        (clk),
        .srst       (srst),
        .cfg_req    (cfg_req),
        .cfg_data   (cfg_data),
        .cfg_ack    (cfg_ack),
        .cfg_rdata  (cfg_rdata),
        .init_done  (init_done),
        .en         (en),
        .sat_en     (sat_en),
        .init_start (init_start)
    );

    // Datapath priority with starvation guard
    update_arbiter #(
        .STARVE_LIMIT (STARVE_LIMIT)
    ) u_arb (
        .clk           (clk),
        .srst          (srst),
        .dp_req        (dp_req),
        .dp_req_data   (dp_req_data),
        .dp_rdy        (dp_rdy),
        .dp_ack        (dp_ack),
        .dp_state      (dp_state),
        .ctrl_req      (ctrl_req),
        .ctrl_req_data (ctrl_req_data),
        .ctrl_rdy      (ctrl_rdy),
        .ctrl_ack      (ctrl_ack),
        .ctrl_state    (ctrl_state),
        .arb_req       (arb_req),
        .arb_data      (arb_data),
        .arb_src       (arb_src),
        .core_rdy      (core_rdy),
        .resp_valid    (resp_valid),
        .resp          (resp)
    );

    state_vector_core u_core (
        .clk        (clk),
        .srst       (srst),
        .en         (en),
        .sat_en     (sat_en),
        .init_done  (init_done),
        .arb_req    (arb_req),
        .arb_data   (arb_data),
        .arb_src    (arb_src),
        .core_rdy   (core_rdy),
        .resp_valid (resp_valid),
        .resp       (resp),
        .rd_id      (rd_id),
        .rd_state   (rd_state),
        .wr_en      (wr_en),
        .wr_id      (wr_id),
        .wr_state   (wr_state)
    );

    state_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_table (
        .clk        (clk),
        .srst       (srst),
        .init_start (init_start),
        .init_done  (init_done),
        .rd_id      (rd_id),
        .rd_state   (rd_state),
        .wr_en      (wr_en),
        .wr_id      (wr_id),
        .wr_state   (wr_state)
    );

endmodule

/* tb/state_subsys_chk.sv */
`timescale 1ns/1ns

module state_subsys_chk #(
    parameter int STARVE_LIMIT = 4
)(
    input logic clk,
    input logic srst,
    input logic dp_req,
    input logic dp_rdy,
    input logic dp_ack,
    input logic ctrl_req,
    input logic ctrl_rdy,
    input logic ctrl_ack,
    input logic core_rdy
);

    int fail_cnt = 0;
    int dp_wins;

    // Datapath grants taken while control kept waiting
    always @(posedge clk) begin
        if (srst || !ctrl_req || ctrl_rdy) dp_wins <= 0;
        else if (dp_req && dp_rdy)         dp_wins <= dp_wins + 1;
    end

    // One ack per accepted request, two cycles later on the same port
    a_dp_ack_latency: assert property (@(posedge clk) disable iff (srst)
        (dp_req && dp_rdy) |-> ##2 dp_ack)
        else begin
            $error("dp_ack missing two cycles after acceptance");
            fail_cnt++;
        end
    a_dp_ack_owned: assert property (@(posedge clk) disable iff (srst)
        dp_ack |-> $past(dp_req && dp_rdy, 2))
        else begin
            $error("dp_ack without an accepted datapath request");
            fail_cnt++;
        end
    a_ctrl_ack_latency: assert property (@(posedge clk) disable iff (srst)
        (ctrl_req && ctrl_rdy) |-> ##2 ctrl_ack)
        else begin
            $error("ctrl_ack missing two cycles after acceptance");
            fail_cnt++;
        end
    a_ctrl_ack_owned: assert property (@(posedge clk) disable iff (srst)
        ctrl_ack |-> $past(ctrl_req && ctrl_rdy, 2))
        else begin
            $error("ctrl_ack without an accepted control request");
            fail_cnt++;
        end
    a_ctrl_idle_grant: assert property (@(posedge clk) disable iff (srst)
        (ctrl_req && !dp_req && core_rdy) |-> ctrl_rdy)
        else begin
            $error("control not granted while datapath idle");
            fail_cnt++;
        end
    a_ctrl_starve_grant: assert property (@(posedge clk) disable iff (srst)
        (ctrl_req && core_rdy && dp_wins >= STARVE_LIMIT) |-> ctrl_rdy)
        else begin
            $error("control not granted at the starvation limit");
            fail_cnt++;
        end

endmodule

/* tb/state_subsys_monitor.sv */
`timescale 1ns/1ns

module state_subsys_monitor #(
    parameter int TABLE_DEPTH = 256
)(
    input logic                   clk,
    input logic                   srst,
    input logic                   dp_req,
    input state_pkg::update_req_t dp_req_data,
    input logic                   dp_rdy,
    input logic                   dp_ack,
    input state_pkg::flow_state_t dp_state,
    input logic                   ctrl_req,
    input state_pkg::update_req_t ctrl_req_data,
    input logic                   ctrl_rdy,
    input logic                   ctrl_ack,
    input state_pkg::flow_state_t ctrl_state,
    input logic                   cfg_req,
    input state_pkg::cfg_req_t    cfg_data,
    input logic                   cfg_ack,
    input logic [7:0]             cfg_rdata
);

    state_pkg::flow_state_t model [256];
    state_pkg::flow_state_t dp_q[$];
    state_pkg::flow_state_t ctrl_q[$];

    logic  en_m;
    logic  sat_m;
    logic  cfg_ack_q;
    logic  exp_rdy;
    int    sweep_left;
    int    err_cnt = 0;
    int    test_base;
    int    tb_base;
    string cur_test = "reset";

    function automatic int pending();
        return dp_q.size() + ctrl_q.size();
    endfunction

    task automatic start_test(input string name, input int tb_errs);
        cur_test  = name;
        test_base = err_cnt;
        tb_base   = tb_errs;
    endtask

    task automatic end_test(input int tb_errs);
        $display("test %s: %0d errors", cur_test, err_cnt - test_base + tb_errs - tb_base);
    endtask

    // ----------------------------
    // Reference update rule
    // ----------------------------
    function automatic state_pkg::flow_state_t apply_rule(input state_pkg::flow_state_t p,
                                                          input state_pkg::update_req_t r);
        state_pkg::flow_state_t n;
        logic [24:0]            bsum;
        n    = p;
        bsum = {1'b0, p.byte_cnt} + {9'd0, r.arg.incr.len};
        if (r.op == state_pkg::OP_INCR) begin
            if (sat_m && p.pkt_cnt == 16'hffff) n.pkt_cnt = 16'hffff;
            else                                n.pkt_cnt = p.pkt_cnt + 16'd1;
            if (sat_m && bsum > 25'h0ffffff) n.byte_cnt = 24'hffffff;
            else                             n.byte_cnt = bsum[23:0];
        end else if (r.op == state_pkg::OP_SET) begin
            n = r.arg.set;
        end
        return n;
    endfunction

    task automatic check_ack(input logic is_ctrl, input state_pkg::flow_state_t act);
        state_pkg::flow_state_t exp;
        if ((is_ctrl ? ctrl_q.size() : dp_q.size()) == 0) begin
            $display("test %s: ack on %s port with no request pending", cur_test,
                     is_ctrl ? "ctrl" : "dp");
            err_cnt++;
        end else begin
            exp = is_ctrl ? ctrl_q.pop_front() : dp_q.pop_front();
            if (act !== exp) begin
                $display("mismatch %s %s: expected %h actual %h", cur_test,
                         is_ctrl ? "ctrl" : "dp", exp, act);
                err_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < 256; i++) model[i] = '0;
            dp_q.delete();
            ctrl_q.delete();
            en_m       = 1'b0;
            sat_m      = 1'b0;
            cfg_ack_q  = 1'b0;
            sweep_left = TABLE_DEPTH;
        end else begin
            // Ready only when enabled and no sweep is running
            exp_rdy = en_m && !(sweep_left > 0 && sweep_left <= TABLE_DEPTH);
            if ((dp_rdy || ctrl_rdy) !== exp_rdy) begin
                $display("mismatch %s rdy: expected %b actual %b", cur_test, exp_rdy,
                         dp_rdy || ctrl_rdy);
                err_cnt++;
            end
            if (sweep_left > 0) sweep_left--;
            if (dp_ack)   check_ack(1'b0, dp_state);
            if (ctrl_ack) check_ack(1'b1, ctrl_state);
            // Acceptance order, one per cycle
            if (dp_req && dp_rdy) begin
                dp_q.push_back(model[dp_req_data.id]);
                model[dp_req_data.id] = apply_rule(model[dp_req_data.id], dp_req_data);
            end else if (ctrl_req && ctrl_rdy) begin
                ctrl_q.push_back(model[ctrl_req_data.id]);
                model[ctrl_req_data.id] = apply_rule(model[ctrl_req_data.id], ctrl_req_data);
            end
            // CTRL readback checked as the ack rises
            if (cfg_ack && !cfg_ack_q && !cfg_data.wr && cfg_data.addr == state_pkg::CFG_CTRL)
            begin
                if (cfg_rdata !== {6'd0, sat_m, en_m}) begin
                    $display("mismatch %s cfg_ctrl: expected %h actual %h", cur_test,
                             {6'd0, sat_m, en_m}, cfg_rdata);
                    err_cnt++;
                end
            end
            if (cfg_req && !cfg_ack && cfg_data.wr && cfg_data.addr == state_pkg::CFG_CTRL) begin
                en_m  = cfg_data.wdata[state_pkg::CTRL_EN_BIT];
                sat_m = cfg_data.wdata[state_pkg::CTRL_SAT_BIT];
                if (cfg_data.wdata[state_pkg::CTRL_INIT_BIT]) begin
                    for (int i = 0; i < 256; i++) model[i] = '0;
                    // Init pulse cycle, then one entry per cycle
                    sweep_left = TABLE_DEPTH + 1;
                end
            end
            cfg_ack_q = cfg_ack;
        end
    end

endmodule

/* tb/tb_state_subsys.sv */
`timescale 1ns/1ns

module tb_state_subsys;

    localparam int STARVE_LIMIT = 4;
    localparam int TABLE_DEPTH  = 256;
    // Traffic cycles over all tests, plus config and single accesses
    localparam int TOTAL_LEN    = 1200;
    localparam int CYCLE_LIMIT  = TOTAL_LEN * 4 + 3 * TABLE_DEPTH;

    logic                   clk;
    logic                   srst;
    logic                   dp_req;
    state_pkg::update_req_t dp_req_data;
    logic                   dp_rdy;
    logic                   dp_ack;
    state_pkg::flow_state_t dp_state;
    logic                   ctrl_req;
    state_pkg::update_req_t ctrl_req_data;
    logic                   ctrl_rdy;
    logic                   ctrl_ack;
    state_pkg::flow_state_t ctrl_state;
    logic                   cfg_req;
    state_pkg::cfg_req_t    cfg_data;
    logic                   cfg_ack;
    logic [7:0]             cfg_rdata;

    logic [31:0] seed;
    int          cycle_cnt = 0;
    int          tb_err;
    int          total_err;

    state_subsys_top #(
        .STARVE_LIMIT (STARVE_LIMIT),
        .TABLE_DEPTH  (TABLE_DEPTH)
    ) uut (.*);

    state_subsys_monitor #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) mon (.*);

    bind update_arbiter state_subsys_chk #(.STARVE_LIMIT(STARVE_LIMIT)) u_chk (
        .clk        (clk),
        .srst       (srst),
        .dp_req     (dp_req),
        .dp_rdy     (dp_rdy),
        .dp_ack     (dp_ack),
        .ctrl_req   (ctrl_req),
        .ctrl_rdy   (ctrl_rdy),
        .ctrl_ack   (ctrl_ack),
        .core_rdy   (core_rdy)
    );

    always #4 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = xorshift(seed);
        r    = seed;
    endtask

    // ----------------------------
    // Config access, four-phase
    // ----------------------------
    task automatic cfg_access(input logic wr, input state_pkg::cfg_addr_t addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        #1;
        if (cfg_ack) begin
            $display("cfg_ack still high before a new request");
            tb_err++;
        end
        cfg_data.addr  = addr;
        cfg_data.wr    = wr;
        cfg_data.wdata = wdata;
        cfg_req        = 1'b1;
        @(posedge clk);
        #1;
        // Ack must follow req by exactly one cycle
        if (!cfg_ack) begin
            $display("cfg_ack did not rise one cycle after cfg_req");
            tb_err++;
        end
        rdata   = cfg_rdata;
        cfg_req = 1'b0;
        @(posedge clk);
        #1;
        if (cfg_ack) begin
            $display("cfg_ack did not fall one cycle after cfg_req dropped");
            tb_err++;
        end
    endtask

    // Poll CFG_STATUS until the sweep is over
    task automatic wait_init_done();
        logic [7:0] rd;
        rd = '0;
        while (!rd[state_pkg::STATUS_INIT_DONE_BIT]) begin
            cfg_access(1'b0, state_pkg::CFG_STATUS, 8'h00, rd);
        end
    endtask

    // One control request, held until accepted
    task automatic ctrl_single(input state_pkg::update_op_t op, input logic [7:0] id,
                               input state_pkg::flow_state_t val);
        @(posedge clk);
        #1;
        ctrl_req_data.id      = id;
        ctrl_req_data.op      = op;
        ctrl_req_data.arg.set = val;
        ctrl_req              = 1'b1;
        @(negedge clk);
        while (!ctrl_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        ctrl_req = 1'b0;
    endtask

    task automatic drain();
        dp_req   = 1'b0;
        ctrl_req = 1'b0;
        while (mon.pending() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // ----------------------------
    // Random traffic over 4 IDs
    // ----------------------------
    task automatic traffic(input int cycles, input logic use_ctrl);
        logic [31:0] r;
        logic [31:0] r2;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            next_rand(r);
            next_rand(r2);
            // Dense datapath, about three cycles in four
            dp_req                     = r[0] | r[1];
            dp_req_data.id             = {6'd0, r[3:2]};
            dp_req_data.op             = state_pkg::OP_INCR;
            dp_req_data.arg.incr.pad   = '0;
            dp_req_data.arg.incr.len   = r[31:16];
            ctrl_req                   = use_ctrl & r[4];
            ctrl_req_data.id           = {6'd0, r[6:5]};
            ctrl_req_data.op           = r[8] ? (r[9] ? state_pkg::OP_READ : state_pkg::OP_SET)
                                              : state_pkg::OP_INCR;
            ctrl_req_data.arg          = {r2[7:0], r2};
        end
        drain();
    endtask

    initial begin
        logic [7:0] rd;
        clk           = 1'b0;
        srst          = 1'b1;
        dp_req        = 1'b0;
        dp_req_data   = '0;
        ctrl_req      = 1'b0;
        ctrl_req_data = '0;
        cfg_req       = 1'b0;
        cfg_data      = '0;
        seed          = 32'h93d3;
        tb_err        = 0;
        repeat (2) @(posedge clk);
        #1;
        srst = 1'b0;

        // 1. Config write, readback and status
        mon.start_test("config", tb_err);
        wait_init_done();
        cfg_access(1'b1, state_pkg::CFG_CTRL, 8'h01, rd);
        cfg_access(1'b0, state_pkg::CFG_CTRL, 8'h00, rd);
        cfg_access(1'b0, state_pkg::CFG_STATUS, 8'h00, rd);
        if (rd !== 8'h01) begin
            $display("mismatch config status: expected %h actual %h", 8'h01, rd);
            tb_err++;
        end
        mon.end_test(tb_err);

        // 2. Wrap, states preset close to the top
        mon.start_test("incr_wrap", tb_err);
        for (int i = 0; i < 4; i++) begin
            ctrl_single(state_pkg::OP_SET, 8'(i), {16'hfff0, 24'hff0000});
        end
        traffic(200, 1'b0);
        mon.end_test(tb_err);

        // 3. Back-to-back and one-apart hits
        mon.start_test("same_id_dense", tb_err);
        traffic(400, 1'b0);
        mon.end_test(tb_err);

        // 4. Control mixed with datapath
        mon.start_test("ctrl_mixed", tb_err);
        traffic(300, 1'b1);
        mon.end_test(tb_err);

        // 5. Saturation
        mon.start_test("saturate", tb_err);
        cfg_access(1'b1, state_pkg::CFG_CTRL, 8'h03, rd);
        for (int i = 0; i < 4; i++) begin
            ctrl_single(state_pkg::OP_SET, 8'(i), {16'hfffe, 24'hfffff0});
        end
        traffic(50, 1'b0);
        mon.end_test(tb_err);

        // 6. Re-init, traffic offered while the sweep runs
        mon.start_test("reinit", tb_err);
        cfg_access(1'b1, state_pkg::CFG_CTRL, 8'h07, rd);
        // Init bit reads back as 0
        cfg_access(1'b0, state_pkg::CFG_CTRL, 8'h00, rd);
        traffic(20, 1'b0);
        wait_init_done();
        for (int i = 0; i < 4; i++) begin
            ctrl_single(state_pkg::OP_READ, 8'(i), '0);
        end
        drain();
        mon.end_test(tb_err);

        total_err = tb_err + mon.err_cnt + uut.u_arb.u_chk.fail_cnt;
        $display("tests 6 errors %0d", total_err);
        if (total_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
common/state_pkg.sv
hw/state_table.sv
hw/update_arbiter.sv
hw/state_cfg_regs.sv
state_vector_core/state_vector_core.sv
hw/state_subsys_top.sv
tb/state_subsys_chk.sv
tb/state_subsys_monitor.sv
tb/tb_state_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, fail status if the log reports failure
verilator --binary --timing --assert -f filelist.f --top-module tb_state_subsys \
    -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
